/* all.f */
+incdir+hw
hw/rename_pkg.sv
hw/rob_if.sv
hw/free_list.sv
hw/map_table.sv
hw/rename_stage.sv
hw/reorder_buffer.sv
hw/rename_core.sv
tb/rename_core_tb.sv

/* hw/free_list.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

module free_list (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  pop,
  output rename_pkg::phys_tag_t pop_tag,
  rob_retire_if.sink            retire
);

  import rename_pkg::*;

  phys_tag_t tags [`NUM_FREE];

  free_ptr_t head_q;
  free_ptr_t tail_q;
  logic      head_wrap_q;
  logic      tail_wrap_q;
  logic      empty;

  // same slot, same lap
  assign empty   = (head_q == tail_q) && (head_wrap_q == tail_wrap_q);
  assign pop_tag = tags[head_q];

  always_ff @(posedge clock) begin
    if (reset) begin
      head_q      <= '0;
      head_wrap_q <= 1'b0;
      tail_q      <= '0;
      tail_wrap_q <= 1'b1;  // starts full
      for (int i = 0; i < `NUM_FREE; i++) begin
        tags[i] <= phys_tag_t'(`NUM_ARCH_REGS + i);
      end
    end else begin
      if (pop) begin
        {head_wrap_q, head_q} <= {head_wrap_q, head_q} + 1'b1;
      end
      if (retire.valid) begin
        tags[tail_q]          <= retire.old_tag;
        {tail_wrap_q, tail_q} <= {tail_wrap_q, tail_q} + 1'b1;
      end
    end
  end

  // credits bound the in-flight count, so the list never runs dry
  a_pop_not_empty: assert property (
    @(posedge clock) disable iff (reset) pop |-> !empty
  ) else $error("free list popped while empty");

endmodule

`default_nettype wire

/* hw/map_table.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

module map_table (
  input  logic                  clock,
  input  logic                  reset,
  input  rename_pkg::arch_idx_t src1,
  input  rename_pkg::arch_idx_t src2,
  output rename_pkg::phys_tag_t src1_tag,
  output logic                  src1_ready,
  output rename_pkg::phys_tag_t src2_tag,
  output logic                  src2_ready,
  input  logic                  write_en,
  input  rename_pkg::arch_idx_t write_idx,
  input  rename_pkg::phys_tag_t write_tag,
  output rename_pkg::phys_tag_t old_tag,
  input  logic                  complete_valid,
  input  rename_pkg::phys_tag_t complete_tag
);

  import rename_pkg::*;

  phys_tag_t                 map_q [`NUM_ARCH_REGS];
  logic [`NUM_PHYS_REGS-1:0] ready_q;
  logic [`NUM_PHYS_REGS-1:0] complete_mask;
  logic [`NUM_PHYS_REGS-1:0] ready_now;

  always_comb begin
    complete_mask               = '0;
    complete_mask[complete_tag] = complete_valid;
  end

  // completion this cycle counts as ready already
  assign ready_now = ready_q | complete_mask;

  assign src1_tag   = map_q[src1];
  assign src2_tag   = map_q[src2];
  assign src1_ready = (src1 == arch_idx_t'(`ZERO_REG)) || ready_now[src1_tag];
  assign src2_ready = (src2 == arch_idx_t'(`ZERO_REG)) || ready_now[src2_tag];
  assign old_tag    = map_q[write_idx];  // read before the write lands

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
        map_q[i] <= phys_tag_t'(i);  // identity
      end
      ready_q <= '1;
    end else begin
      ready_q <= ready_now;
      if (write_en) begin
        map_q[write_idx]   <= write_tag;
        ready_q[write_tag] <= 1'b0;  // fresh tag waits for its producer
      end
    end
  end

  // a tag completes once per allocation
  a_complete_once: assert property (
    @(posedge clock) disable iff (reset) complete_valid |-> !ready_q[complete_tag]
  ) else $error("completion of tag %0d which is already ready", complete_tag);

endmodule

`default_nettype wire

/* hw/rename_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

module rename_core (
  input  logic                  clock,
  input  logic                  reset,
  // dispatch
  input  logic                  dispatch_valid,
  input  rename_pkg::arch_idx_t dispatch_dest,
  input  rename_pkg::arch_idx_t dispatch_src1,
  input  rename_pkg::arch_idx_t dispatch_src2,
  input  logic                  dispatch_halt,
  // rename result, one cycle after dispatch
  output logic                  rename_valid,
  output rename_pkg::phys_tag_t rename_dest_tag,
  output rename_pkg::phys_tag_t rename_src1_tag,
  output logic                  rename_src1_ready,
  output rename_pkg::phys_tag_t rename_src2_tag,
  output logic                  rename_src2_ready,
  output rename_pkg::rob_idx_t  rename_rob_idx,
  // completion broadcast
  input  logic                  complete_valid,
  input  rename_pkg::phys_tag_t complete_tag,
  // commit
  output logic                  commit_valid,
  output logic                  commit_wr_en,
  output rename_pkg::arch_idx_t commit_arch_idx,
  output rename_pkg::phys_tag_t commit_tag,
  output logic                  credit_return,
  output logic                  halted
);

  import rename_pkg::*;

  rob_alloc_if  alloc_if ();
  rob_retire_if retire_if ();

  rename_stage rename_stage_0 (
    .clock             (clock),
    .reset             (reset),
    .dispatch_valid    (dispatch_valid),
    .dispatch_dest     (dispatch_dest),
    .dispatch_src1     (dispatch_src1),
    .dispatch_src2     (dispatch_src2),
    .dispatch_halt     (dispatch_halt),
    .complete_valid    (complete_valid),
    .complete_tag      (complete_tag),
    .alloc             (alloc_if),
    .retire            (retire_if),
    .rename_valid      (rename_valid),
    .rename_dest_tag   (rename_dest_tag),
    .rename_src1_tag   (rename_src1_tag),
    .rename_src1_ready (rename_src1_ready),
    .rename_src2_tag   (rename_src2_tag),
    .rename_src2_ready (rename_src2_ready),
    .rename_rob_idx    (rename_rob_idx)
  );

  reorder_buffer rob_0 (
    .clock          (clock),
    .reset          (reset),
    .alloc          (alloc_if),
    .complete_valid (complete_valid),
    .complete_tag   (complete_tag),
    .retire         (retire_if),
    .credit_return  (credit_return),
    .halted         (halted)
  );

  assign commit_valid    = retire_if.valid;
  assign commit_arch_idx = retire_if.arch_idx;
  assign commit_tag      = retire_if.new_tag;

  // r31 is hardwired, halt lands there too
  assign commit_wr_en = retire_if.valid && (retire_if.arch_idx != arch_idx_t'(`ZERO_REG));

endmodule

`default_nettype wire

/* hw/rename_params.svh */
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// register file sizes
`define NUM_ARCH_REGS 32
`define NUM_PHYS_REGS 64

// free tags left once every arch reg holds one
`define NUM_FREE      32

// reorder buffer slots, also the dispatch credits after reset
`define NUM_ROB       16

`define ZERO_REG      31  // never written at commit

`endif

/* hw/rename_pkg.sv */
`default_nettype none

`include "rename_params.svh"

package rename_pkg;

  // architectural register index
  typedef logic [$clog2(`NUM_ARCH_REGS)-1:0] arch_idx_t;

  // physical register tag
  typedef logic [$clog2(`NUM_PHYS_REGS)-1:0] phys_tag_t;

  typedef logic [$clog2(`NUM_ROB)-1:0]       rob_idx_t;

  // slot in the free list, wrap bit lives in free_list
  typedef logic [$clog2(`NUM_FREE)-1:0]      free_ptr_t;

  // retirement run state
  typedef enum logic {
    RUNNING,
    HALTED
  } rob_state_t;

endpackage

`default_nettype wire

/* hw/rename_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

module rename_stage (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  dispatch_valid,
  input  rename_pkg::arch_idx_t dispatch_dest,
  input  rename_pkg::arch_idx_t dispatch_src1,
  input  rename_pkg::arch_idx_t dispatch_src2,
  input  logic                  dispatch_halt,
  input  logic                  complete_valid,
  input  rename_pkg::phys_tag_t complete_tag,
  rob_alloc_if.source           alloc,
  rob_retire_if.sink            retire,
  output logic                  rename_valid,
  output rename_pkg::phys_tag_t rename_dest_tag,
  output rename_pkg::phys_tag_t rename_src1_tag,
  output logic                  rename_src1_ready,
  output rename_pkg::phys_tag_t rename_src2_tag,
  output logic                  rename_src2_ready,
  output rename_pkg::rob_idx_t  rename_rob_idx
);

  import rename_pkg::*;

  arch_idx_t dest_idx;
  phys_tag_t new_tag;
  phys_tag_t old_tag;
  phys_tag_t src1_tag;
  phys_tag_t src2_tag;
  logic      src1_ready;
  logic      src2_ready;

  // halt writes nothing, so it is renamed onto the zero register
  assign dest_idx = dispatch_halt ? arch_idx_t'(`ZERO_REG) : dispatch_dest;

  map_table map_table_0 (
    .clock          (clock),
    .reset          (reset),
    .src1           (dispatch_src1),
    .src2           (dispatch_src2),
    .src1_tag       (src1_tag),
    .src1_ready     (src1_ready),
    .src2_tag       (src2_tag),
    .src2_ready     (src2_ready),
    .write_en       (dispatch_valid),
    .write_idx      (dest_idx),
    .write_tag      (new_tag),
    .old_tag        (old_tag),
    .complete_valid (complete_valid),
    .complete_tag   (complete_tag)
  );

  free_list free_list_0 (
    .clock   (clock),
    .reset   (reset),
    .pop     (dispatch_valid),
    .pop_tag (new_tag),
    .retire  (retire)
  );

  assign alloc.valid    = dispatch_valid;
  assign alloc.arch_idx = dest_idx;
  assign alloc.new_tag  = new_tag;
  assign alloc.old_tag  = old_tag;
  assign alloc.halt     = dispatch_halt;

  always_ff @(posedge clock) begin
    if (reset) begin
      rename_valid <= 1'b0;
    end else begin
      rename_valid <= dispatch_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (dispatch_valid) begin
      rename_dest_tag   <= new_tag;
      rename_src1_tag   <= src1_tag;
      rename_src1_ready <= src1_ready;
      rename_src2_tag   <= src2_tag;
      rename_src2_ready <= src2_ready;
      rename_rob_idx    <= alloc.rob_idx;  // slot taken on this edge
    end
  end

endmodule

`default_nettype wire

/* hw/reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

module reorder_buffer (
  input  logic                  clock,
  input  logic                  reset,
  rob_alloc_if.sink             alloc,
  input  logic                  complete_valid,
  input  rename_pkg::phys_tag_t complete_tag,
  rob_retire_if.source          retire,
  output logic                  credit_return,
  output logic                  halted
);

  import rename_pkg::*;

  // entry payload
  arch_idx_t entry_arch_q [`NUM_ROB];
  phys_tag_t entry_new_q  [`NUM_ROB];
  phys_tag_t entry_old_q  [`NUM_ROB];
  logic      entry_halt_q [`NUM_ROB];

  logic [`NUM_ROB-1:0]       valid_q;
  logic [`NUM_ROB-1:0]       done_q;
  logic [`NUM_ROB-1:0]       complete_hit;
  rob_idx_t                  head_q;
  rob_idx_t                  tail_q;
  logic [$clog2(`NUM_ROB):0] count_q;
  rob_state_t                state_q;
  logic                      retire_fire;
  logic                      full;

  always_comb begin
    for (int i = 0; i < `NUM_ROB; i++) begin
      complete_hit[i] = complete_valid && valid_q[i] && (entry_new_q[i] == complete_tag);
    end
  end

  assign full        = count_q == `NUM_ROB;
  assign retire_fire = valid_q[head_q] && done_q[head_q] && (state_q == RUNNING);

  assign alloc.rob_idx   = tail_q;
  assign retire.valid    = retire_fire;
  assign retire.arch_idx = entry_arch_q[head_q];
  assign retire.new_tag  = entry_new_q[head_q];
  assign retire.old_tag  = entry_old_q[head_q];
  assign credit_return   = retire_fire;  // one slot back per commit
  assign halted          = state_q == HALTED;

  always_ff @(posedge clock) begin
    if (reset) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      valid_q <= '0;
      done_q  <= '0;
      state_q <= RUNNING;
    end else begin
      done_q <= done_q | complete_hit;
      if (alloc.valid) begin
        valid_q[tail_q] <= 1'b1;
        done_q[tail_q]  <= 1'b0;
        tail_q          <= tail_q + 1'b1;
      end
      if (retire_fire) begin
        valid_q[head_q] <= 1'b0;
        head_q          <= head_q + 1'b1;
        if (entry_halt_q[head_q]) begin
          state_q <= HALTED;  // stays until reset
        end
      end
      case ({alloc.valid, retire_fire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (alloc.valid) begin
      entry_arch_q[tail_q] <= alloc.arch_idx;
      entry_new_q[tail_q]  <= alloc.new_tag;
      entry_old_q[tail_q]  <= alloc.old_tag;
      entry_halt_q[tail_q] <= alloc.halt;
    end
  end

  // producer dispatched without a credit
  a_no_alloc_full: assert property (
    @(posedge clock) disable iff (reset) alloc.valid |-> !full
  ) else $error("allocation into a full reorder buffer");

endmodule

`default_nettype wire

/* hw/rob_if.sv */
`timescale 1ns/1ps
`default_nettype none

// rename stage to reorder buffer
interface rob_alloc_if ();
  logic                  valid;
  rename_pkg::arch_idx_t arch_idx;
  rename_pkg::phys_tag_t new_tag;
  rename_pkg::phys_tag_t old_tag;  // previous mapping of arch_idx
  logic                  halt;
  rename_pkg::rob_idx_t  rob_idx;  // tail slot, driven back by the buffer

  modport source (
    output valid, arch_idx, new_tag, old_tag, halt,
    input  rob_idx
  );

  modport sink (
    input  valid, arch_idx, new_tag, old_tag, halt,
    output rob_idx
  );
endinterface

// in-order retirement out of the reorder buffer
interface rob_retire_if ();
  logic                  valid;
  rename_pkg::arch_idx_t arch_idx;
  rename_pkg::phys_tag_t new_tag;
  rename_pkg::phys_tag_t old_tag;  // goes back to the free list

  modport source (output valid, arch_idx, new_tag, old_tag);
  modport sink (input valid, arch_idx, new_tag, old_tag);
endinterface

`default_nettype wire

/* tb/rename_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

module rename_core_tb;

  import rename_pkg::*;

  // five resets and a few hundred cycles of traffic leave a wide margin
  localparam int WATCHDOG_CYCLES = 2000;

  typedef struct packed {
    arch_idx_t arch;
    phys_tag_t new_tag;
    phys_tag_t old_tag;
    logic      halt;
  } rob_entry_t;

  logic      clock = 1'b0;
  logic      reset;
  logic      dispatch_valid;
  arch_idx_t dispatch_dest;
  arch_idx_t dispatch_src1;
  arch_idx_t dispatch_src2;
  logic      dispatch_halt;
  logic      rename_valid;
  phys_tag_t rename_dest_tag;
  phys_tag_t rename_src1_tag;
  logic      rename_src1_ready;
  phys_tag_t rename_src2_tag;
  logic      rename_src2_ready;
  rob_idx_t  rename_rob_idx;
  logic      complete_valid;
  phys_tag_t complete_tag;
  logic      commit_valid;
  logic      commit_wr_en;
  arch_idx_t commit_arch_idx;
  phys_tag_t commit_tag;
  logic      credit_return;
  logic      halted;

  // reference model
  phys_tag_t                 map_m [`NUM_ARCH_REGS];
  logic [`NUM_PHYS_REGS-1:0] model_ready;  // also the done bit of in-flight entries
  phys_tag_t                 free_q [$];
  rob_entry_t                rob_m [$];
  int                        credits;
  rob_idx_t                  alloc_count;
  logic                      model_halted;

  // rename result expected after the next edge
  logic      exp_valid;
  phys_tag_t exp_dest;
  phys_tag_t exp_src1;
  logic      exp_ready1;
  phys_tag_t exp_src2;
  logic      exp_ready2;
  rob_idx_t  exp_idx;

  string       test_name;
  logic [31:0] rng_state = 32'd59058;

  rename_core DUT (.*);

  always #10 clock = ~clock;

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, test_name);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped by the watchdog");
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int random_below(input int n);
    rng_state = xorshift(rng_state);
    return int'(rng_state % n);
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "stopping at first error");
  endtask

  task automatic tag_check(input string what, input phys_tag_t exp, input phys_tag_t act);
    if (act !== exp)
      abort_run($sformatf("Fail %s %s: expected %0d, actual %0d", test_name, what, exp, act));
  endtask

  task automatic arch_check(input string what, input arch_idx_t exp, input arch_idx_t act);
    if (act !== exp)
      abort_run($sformatf("Fail %s %s: expected %0d, actual %0d", test_name, what, exp, act));
  endtask

  task automatic rob_check(input string what, input rob_idx_t exp, input rob_idx_t act);
    if (act !== exp)
      abort_run($sformatf("Fail %s %s: expected %0d, actual %0d", test_name, what, exp, act));
  endtask

  task automatic bit_check(input string what, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("Fail %s %s: expected %0b, actual %0b", test_name, what, exp, act));
  endtask

  task automatic apply_reset();
    reset          = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_halt  = 1'b0;
    complete_valid = 1'b0;
    repeat (10) @(negedge clock);
    reset = 1'b0;
    for (int i = 0; i < `NUM_ARCH_REGS; i++) map_m[i] = phys_tag_t'(i);
    model_ready = '1;
    free_q.delete();
    for (int i = 0; i < `NUM_FREE; i++) free_q.push_back(phys_tag_t'(`NUM_ARCH_REGS + i));
    rob_m.delete();
    credits      = `NUM_ROB;
    alloc_count  = '0;
    model_halted = 1'b0;
    exp_valid    = 1'b0;
  endtask

  // one cycle from falling edge to falling edge
  task automatic step(input logic disp, input arch_idx_t dest, input arch_idx_t src1,
                      input arch_idx_t src2, input logic halt, input logic comp,
                      input phys_tag_t ctag);
    rob_entry_t head;
    rob_entry_t entry;
    logic       exp_commit;
    exp_commit = 1'b0;
    bit_check("halted", model_halted, halted);
    if (!model_halted && rob_m.size() > 0 && model_ready[rob_m[0].new_tag]) begin
      exp_commit = 1'b1;
      head       = rob_m.pop_front();
      bit_check("commit_wr_en", head.arch != arch_idx_t'(`ZERO_REG), commit_wr_en);
      arch_check("commit_arch_idx", head.arch, commit_arch_idx);
      tag_check("commit_tag", head.new_tag, commit_tag);
      free_q.push_back(head.old_tag);  // lands at the same edge as the head moves
      if (head.halt) model_halted = 1'b1;
    end
    bit_check("commit_valid", exp_commit, commit_valid);
    bit_check("credit_return", exp_commit, credit_return);
    bit_check("rename_valid", exp_valid, rename_valid);
    if (exp_valid) begin
      tag_check("rename_dest_tag", exp_dest, rename_dest_tag);
      tag_check("rename_src1_tag", exp_src1, rename_src1_tag);
      bit_check("rename_src1_ready", exp_ready1, rename_src1_ready);
      tag_check("rename_src2_tag", exp_src2, rename_src2_tag);
      bit_check("rename_src2_ready", exp_ready2, rename_src2_ready);
      rob_check("rename_rob_idx", exp_idx, rename_rob_idx);
    end

    dispatch_valid = disp;
    dispatch_dest  = dest;
    dispatch_src1  = src1;
    dispatch_src2  = src2;
    dispatch_halt  = halt;
    complete_valid = comp;
    complete_tag   = ctag;
    exp_valid      = disp;
    if (disp) begin
      if (credits == 0) abort_run("test sequence dispatched without holding a credit");
      credits--;
      entry.arch    = halt ? arch_idx_t'(`ZERO_REG) : dest;  // halt renames onto r31
      entry.new_tag = free_q.pop_front();
      entry.old_tag = map_m[entry.arch];
      entry.halt    = halt;
      rob_m.push_back(entry);
      exp_dest   = entry.new_tag;
      exp_idx    = alloc_count;
      exp_src1   = map_m[src1];
      exp_src2   = map_m[src2];
      exp_ready1 = src1 == arch_idx_t'(`ZERO_REG) || model_ready[exp_src1] ||
                   (comp && ctag == exp_src1);
      exp_ready2 = src2 == arch_idx_t'(`ZERO_REG) || model_ready[exp_src2] ||
                   (comp && ctag == exp_src2);
      alloc_count++;
    end
    if (exp_commit) credits++;  // a returned credit is usable from the next cycle
    if (comp) model_ready[ctag] = 1'b1;
    if (disp) begin
      map_m[entry.arch]          = entry.new_tag;
      model_ready[entry.new_tag] = 1'b0;
    end
    @(negedge clock);
  endtask

  task automatic pick_pending(output logic found, output phys_tag_t tag);
    phys_tag_t open_tags [$];
    foreach (rob_m[i]) begin
      if (!model_ready[rob_m[i].new_tag]) open_tags.push_back(rob_m[i].new_tag);
    end
    found = open_tags.size() > 0;
    tag   = '0;
    if (found) tag = open_tags[random_below(open_tags.size())];
  endtask

  function automatic arch_idx_t any_reg();
    return arch_idx_t'(random_below(`NUM_ARCH_REGS));
  endfunction

  // complete everything in flight in random order, then let it retire
  task automatic drain();
    logic      found;
    phys_tag_t tag;
    while (rob_m.size() > 0) begin
      pick_pending(found, tag);
      step(1'b0, '0, '0, '0, 1'b0, found, tag);
    end
    step(1'b0, '0, '0, '0, 1'b0, 1'b0, '0);
  endtask

  task automatic random_traffic(input int n);
    int        sent;
    logic      found;
    logic      disp;
    phys_tag_t tag;
    sent = 0;
    while (sent < n || rob_m.size() > 0) begin
      pick_pending(found, tag);
      found = found && random_below(2) == 0;
      disp  = sent < n && credits > 0 && random_below(4) != 0;
      step(disp, any_reg(), any_reg(), any_reg(), 1'b0, found, tag);
      if (disp) sent++;
    end
    step(1'b0, '0, '0, '0, 1'b0, 1'b0, '0);
  endtask

  task automatic first_dispatch();
    test_name = "first_dispatch";
    apply_reset();
    repeat (4) step(1'b1, any_reg(), any_reg(), any_reg(), 1'b0, 1'b0, '0);
    drain();
  endtask

  task automatic dependency_chain();
    phys_tag_t producer;
    test_name = "dependency_chain";
    apply_reset();
    step(1'b1, 5'd5, 5'd1, 5'd2, 1'b0, 1'b0, '0);
    producer = map_m[5];
    step(1'b1, 5'd6, 5'd5, 5'd5, 1'b0, 1'b0, '0);      // waits on the producer
    step(1'b1, 5'd7, 5'd5, 5'd6, 1'b0, 1'b1, producer); // forwarded in the same cycle
    step(1'b1, 5'd8, 5'd5, 5'd7, 1'b0, 1'b0, '0);
    drain();
  endtask

  task automatic out_of_order_commit();
    test_name = "out_of_order_commit";
    apply_reset();
    random_traffic(40);
  endtask

  task automatic credit_recycling();
    test_name = "credit_recycling";
    apply_reset();
    // four full rounds wrap the 32 entry free list
    repeat (4) begin
      repeat (`NUM_ROB) step(1'b1, any_reg(), any_reg(), any_reg(), 1'b0, 1'b0, '0);
      drain();
    end
  endtask

  task automatic zero_reg_and_halt();
    test_name = "zero_reg_and_halt";
    apply_reset();
    step(1'b1, arch_idx_t'(`ZERO_REG), arch_idx_t'(`ZERO_REG), 5'd3, 1'b0, 1'b0, '0);
    drain();
    step(1'b1, 5'd4, 5'd1, 5'd2, 1'b1, 1'b0, '0);  // halt
    step(1'b1, 5'd9, 5'd4, 5'd31, 1'b0, 1'b0, '0);
    step(1'b0, '0, '0, '0, 1'b0, 1'b1, rob_m[1].new_tag);
    step(1'b0, '0, '0, '0, 1'b0, 1'b1, rob_m[0].new_tag);
    repeat (6) step(1'b0, '0, '0, '0, 1'b0, 1'b0, '0);
    bit_check("halted after halt commit", 1'b1, halted);
  endtask

  initial begin
    test_name      = "reset";
    reset          = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_dest  = '0;
    dispatch_src1  = '0;
    dispatch_src2  = '0;
    dispatch_halt  = 1'b0;
    complete_valid = 1'b0;
    complete_tag   = '0;
    first_dispatch();
    dependency_chain();
    out_of_order_commit();
    credit_recycling();
    zero_reg_and_halt();
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire
